// File: verilog.f
+incdir+src
src/vga_timing_pkg.sv
src/vga_pixel_pkg.sv
src/vga_raster_timer.sv
src/bar_config_regs.sv
src/bar_scroller.sv
src/bar_renderer.sv
src/vga_scrolling_bar.sv
tests/tb_vga_scrolling_bar.sv

// File: Makefile
# Verilator simulation of the scrolling bar generator

VERILATOR ?= verilator
TOP       ?= tb_vga_scrolling_bar
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_vga_scrolling_bar.sv
`timescale 1ns/1ps

`include "vga_settings.svh"

module tb_vga_scrolling_bar;

    localparam int FRAME_CYCLES = `VGA_H_TOTAL * `VGA_V_TOTAL;
    localparam int RUN_CYCLES   = 2 * FRAME_CYCLES + 4;          // Two frames plus the last commit
    localparam int CYCLE_LIMIT  = 2 * FRAME_CYCLES * 105 / 100;  // Two frames plus 5%
    localparam int ACK_WAIT     = 2;                             // Cycles allowed per handshake edge

    logic                    clk;
    logic                    reset_n;
    logic                    cfg_req;
    vga_pixel_pkg::cfg_cmd_t cfg_cmd;
    logic                    cfg_ack;
    logic                    h_sync;
    logic                    v_sync;
    logic                    video_on;
    vga_pixel_pkg::rgb_t     rgb;

    // Reference model state
    int unsigned ref_h;
    int unsigned ref_v;
    int unsigned ref_offset;
    int unsigned ref_speed;
    int unsigned ref_div;
    int unsigned ref_width;
    logic [23:0] ref_bar;
    logic [23:0] ref_bg;
    logic        ref_pending;
    logic        ref_acked;

    // Expected port values start at the reset values
    logic        exp_hsync = 1'b1;
    logic        exp_vsync = 1'b1;
    logic        exp_video = 1'b0;
    logic [23:0] exp_rgb   = '0;
    logic        exp_ack   = 1'b0;

    int unsigned cycle          = 0;
    int unsigned mismatch_count = 0;
    int unsigned failure_count  = 0;

    vga_scrolling_bar i_dut (
        .clk     (clk),
        .reset_n (reset_n),
        .cfg_req (cfg_req),
        .cfg_cmd (cfg_cmd),
        .cfg_ack (cfg_ack),
        .h_sync  (h_sync),
        .v_sync  (v_sync),
        .video_on(video_on),
        .rgb     (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 25 MHz pixel clock
    end

    // Compare one port against the model
    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatch_count++;
            $display("mismatch %s: expected %h, actual %h at cycle %0d",
                     what, expected, actual, cycle);
        end
    endtask

    // Four-phase write with req driven 2 ns after the edge
    task automatic config_write(input vga_pixel_pkg::cfg_field_e field, input logic [23:0] value);
        int waited;
        @(posedge clk);
        #2;
        cfg_cmd.field = field;
        cfg_cmd.value = value;
        cfg_req       = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!cfg_ack && waited < ACK_WAIT);
        assert (cfg_ack) else begin
            failure_count++;
            $display("configuration ack did not rise within %0d cycles of req", ACK_WAIT);
        end
        @(posedge clk);
        #2 cfg_req = 1'b0;  // Release req and leave cmd as it is
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (cfg_ack && waited < ACK_WAIT);
        assert (!cfg_ack) else begin
            failure_count++;
            $display("configuration ack did not fall within %0d cycles of req release", ACK_WAIT);
        end
    endtask

    function automatic logic [23:0] random_divider();
        return 24'(200 + $urandom % 2801);  // 200 to 3000 clocks per step
    endfunction

    // Model evaluated on the state the DUT sees at each edge
    always @(posedge clk) begin
        int unsigned col;
        logic        write;
        logic        div_write;
        logic        at_frame;
        logic        reached;
        if (!reset_n) begin
            ref_h       = 0;
            ref_v       = 0;
            ref_offset  = 0;
            ref_speed   = 0;
            ref_pending = 1'b0;
            ref_acked   = 1'b0;
            ref_width   = `BAR_DEFAULT_WIDTH;
            ref_div     = `BAR_DEFAULT_DIVIDER;
            ref_bar     = `BAR_DEFAULT_COLOR;
            ref_bg      = `BG_DEFAULT_COLOR;
            exp_hsync   = 1'b1;
            exp_vsync   = 1'b1;
            exp_video   = 1'b0;
            exp_rgb     = '0;
            exp_ack     = 1'b0;
        end else begin
            // Registered pixel from the counters before this edge
            exp_video = (ref_h < `VGA_H_ACTIVE) && (ref_v < `VGA_V_ACTIVE);
            exp_hsync = !((ref_h >= `VGA_H_SYNC_START) && (ref_h < `VGA_H_SYNC_END));
            exp_vsync = !((ref_v >= `VGA_V_SYNC_START) && (ref_v < `VGA_V_SYNC_END));
            col       = (ref_h + ref_offset) % `VGA_H_ACTIVE;  // Wraps the bar across the edge
            if (!exp_video)
                exp_rgb = '0;
            else
                exp_rgb = (col < ref_width) ? ref_bar : ref_bg;

            at_frame  = (ref_h == 0) && (ref_v == 0);
            write     = !ref_acked && cfg_req;
            div_write = write && (cfg_cmd.field == vga_pixel_pkg::CFG_DIVIDER);
            reached   = (ref_speed == ref_div - 1);

            // Scroll step committed only at frame start
            if (at_frame) begin
                if (!div_write && (ref_pending || reached))
                    ref_offset = (ref_offset + 1) % `VGA_H_ACTIVE;
                ref_pending = 1'b0;
            end else if (div_write) begin
                ref_pending = 1'b0;  // Divider write drops the step
            end else if (reached) begin
                ref_pending = 1'b1;
            end
            ref_speed = (div_write || reached) ? 0 : ref_speed + 1;

            if (write) begin
                case (cfg_cmd.field)
                    vga_pixel_pkg::CFG_BAR_WIDTH: ref_width = cfg_cmd.value & 24'h3FF;
                    vga_pixel_pkg::CFG_DIVIDER:   ref_div   = cfg_cmd.value & 24'hFFFFF;
                    vga_pixel_pkg::CFG_BAR_COLOR: ref_bar   = cfg_cmd.value;
                    default:                      ref_bg    = cfg_cmd.value;
                endcase
            end
            if (!ref_acked && cfg_req)
                ref_acked = 1'b1;
            else if (ref_acked && !cfg_req)
                ref_acked = 1'b0;  // Four-phase release
            exp_ack = ref_acked;

            // Raster counters
            if (ref_h == `VGA_H_TOTAL - 1) begin
                ref_h = 0;
                ref_v = (ref_v == `VGA_V_TOTAL - 1) ? 0 : ref_v + 1;
            end else begin
                ref_h = ref_h + 1;
            end
        end
    end

    // Ports are stable at the falling edge
    always @(negedge clk) begin
        check_value("raster h_sync", 32'(exp_hsync), 32'(h_sync));
        check_value("raster v_sync", 32'(exp_vsync), 32'(v_sync));
        check_value("raster video_on", 32'(exp_video), 32'(video_on));
        check_value("pixel rgb", 32'(exp_rgb), 32'(rgb));
        check_value("handshake ack", 32'(exp_ack), 32'(cfg_ack));
    end

    // Run limit
    always @(posedge clk) begin
        if (reset_n)
            cycle++;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int unsigned gap;
        cfg_req = 1'b0;
        cfg_cmd = '0;
        reset_n = 1'b0;
        void'($urandom(95877));
        repeat (3) @(posedge clk);
        #2 reset_n = 1'b1;

        // Each field once with the divider first so the bar moves in frame one
        config_write(vga_pixel_pkg::CFG_DIVIDER, random_divider());
        config_write(vga_pixel_pkg::CFG_BAR_WIDTH, 24'($urandom));
        config_write(vga_pixel_pkg::CFG_BAR_COLOR, 24'($urandom));
        config_write(vga_pixel_pkg::CFG_BG_COLOR, 24'($urandom));

        while (cycle < RUN_CYCLES) begin
            gap = 1 + $urandom % 60000;
            for (int i = 0; i < gap && cycle < RUN_CYCLES; i++)
                @(negedge clk);
            // Writes stay clear of the frame end so a step is pending at the boundary
            if (cycle < RUN_CYCLES && ref_v < 400) begin
                case ($urandom % 4)
                    0:       config_write(vga_pixel_pkg::CFG_BAR_WIDTH, 24'($urandom));
                    1:       config_write(vga_pixel_pkg::CFG_DIVIDER, random_divider());
                    2:       config_write(vga_pixel_pkg::CFG_BAR_COLOR, 24'($urandom));
                    default: config_write(vga_pixel_pkg::CFG_BG_COLOR, 24'($urandom));
                endcase
            end
        end

        $display("Done after %0d cycles: %0d mismatches, %0d other failures",
                 cycle, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: src/vga_scrolling_bar.sv
`timescale 1ns/1ps

module vga_scrolling_bar (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    cfg_req,
    input  vga_pixel_pkg::cfg_cmd_t cfg_cmd,
    output logic                    cfg_ack,
    output logic                    h_sync,    // Active low
    output logic                    v_sync,    // Active low
    output logic                    video_on,
    output vga_pixel_pkg::rgb_t     rgb
);

    vga_timing_pkg::h_pos_t       h_pos;
    vga_timing_pkg::sync_bundle_t raster_sync;  // Undelayed, from the counters
    vga_timing_pkg::sync_bundle_t pixel_sync;   // Aligned with rgb
    logic                         frame_start;
    vga_pixel_pkg::bar_cfg_t      cfg;
    logic                         divider_written;
    vga_timing_pkg::h_pos_t       offset;

    // The line number is not needed, the bar spans every line
    vga_raster_timer i_raster_timer (
        .clk        (clk),
        .reset_n    (reset_n),
        .h_pos      (h_pos),
        .v_pos      (),
        .sync       (raster_sync),
        .frame_start(frame_start)
    );

    bar_config_regs i_bar_config_regs (
        .clk            (clk),
        .reset_n        (reset_n),
        .cfg_req        (cfg_req),
        .cfg_cmd        (cfg_cmd),
        .cfg_ack        (cfg_ack),
        .cfg            (cfg),
        .divider_written(divider_written)
    );

    bar_scroller i_bar_scroller (
        .clk            (clk),
        .reset_n        (reset_n),
        .divider        (cfg.divider),
        .divider_written(divider_written),
        .frame_start    (frame_start),
        .offset         (offset)
    );

    bar_renderer i_bar_renderer (
        .clk     (clk),
        .reset_n (reset_n),
        .h_pos   (h_pos),
        .sync_in (raster_sync),
        .offset  (offset),
        .cfg     (cfg),
        .sync_out(pixel_sync),
        .rgb     (rgb)
    );

    assign h_sync   = pixel_sync.h_sync;
    assign v_sync   = pixel_sync.v_sync;
    assign video_on = pixel_sync.video_on;

endmodule

// File: src/bar_renderer.sv
`timescale 1ns/1ps

`include "vga_settings.svh"

module bar_renderer (
    input  logic                         clk,
    input  logic                         reset_n,
    input  vga_timing_pkg::h_pos_t       h_pos,
    input  vga_timing_pkg::sync_bundle_t sync_in,   // Same cycle as h_pos
    input  vga_timing_pkg::h_pos_t       offset,    // Committed scroll offset
    input  vga_pixel_pkg::bar_cfg_t      cfg,
    output vga_timing_pkg::sync_bundle_t sync_out,  // Delayed to match rgb
    output vga_pixel_pkg::rgb_t          rgb
);

    logic [10:0]                  pos_sum;   // Up to 799 + 639
    logic [10:0]                  pos_wrap;
    vga_timing_pkg::h_pos_t       wrapped;   // Screen column shifted by the offset
    logic                         in_bar;
    vga_pixel_pkg::rgb_t          pix;
    vga_timing_pkg::sync_bundle_t sync_q;
    vga_pixel_pkg::rgb_t          rgb_q;

    // One subtraction is enough inside the active area
    assign pos_sum  = {1'b0, h_pos} + {1'b0, offset};
    assign pos_wrap = (pos_sum >= 11'(`VGA_H_ACTIVE)) ? pos_sum - 11'(`VGA_H_ACTIVE) : pos_sum;
    assign wrapped  = pos_wrap[9:0];
    assign in_bar   = (wrapped < cfg.width);

    // Color mux
    always_comb begin
        if (!sync_in.video_on)
            pix = '0;                // Black in blanking
        else if (in_bar)
            pix = cfg.bar_color;
        else
            pix = cfg.bg_color;     // Background
    end

    // Output stage, sync and color leave together
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sync_q.h_sync   <= 1'b1;  // Inactive
            sync_q.v_sync   <= 1'b1;
            sync_q.video_on <= 1'b0;
            rgb_q           <= '0;
        end else begin
            sync_q <= sync_in;
            rgb_q  <= pix;
        end
    end

    assign sync_out = sync_q;
    assign rgb      = rgb_q;

endmodule

// File: src/bar_scroller.sv
`timescale 1ns/1ps

`include "vga_settings.svh"

module bar_scroller (
    input  logic                    clk,
    input  logic                    reset_n,
    input  vga_pixel_pkg::divider_t divider,          // Clocks per step
    input  logic                    divider_written,  // Restart the step timing
    input  logic                    frame_start,
    output vga_timing_pkg::h_pos_t  offset            // Bar shift, 0 to 639
);

    vga_pixel_pkg::divider_t speed_cnt;
    vga_pixel_pkg::divider_t div_last;  // Terminal count
    logic                    tick;      // Divider period complete
    logic                    pending;   // Step waiting for the next frame
    logic                    step;      // Apply one step at this frame start
    vga_timing_pkg::h_pos_t  offset_q;
    vga_timing_pkg::h_pos_t  offset_inc;

    // A divider of 0 behaves like 1
    assign div_last = (divider == '0) ? '0 : divider - 1'b1;
    assign tick     = (speed_cnt >= div_last);

    // A step landing on the frame start cycle still counts, a divider write drops it
    assign step = !divider_written && (pending || tick);

    // Wrap at the visible width
    assign offset_inc = (offset_q == vga_timing_pkg::h_pos_t'(`VGA_H_ACTIVE - 1)) ?
                        '0 : offset_q + 1'b1;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            speed_cnt <= '0;
            pending   <= 1'b0;
            offset_q  <= '0;
        end else begin
            // Speed divider
            if (divider_written || tick)
                speed_cnt <= '0;
            else
                speed_cnt <= speed_cnt + 1'b1;

            if (frame_start) begin
                if (step) offset_q <= offset_inc;  // Commit once per frame
                pending <= 1'b0;
            end else if (divider_written) begin
                pending <= 1'b0;
            end else if (tick) begin
                pending <= 1'b1;  // Extra ticks before the frame are merged
            end
        end
    end

    assign offset = offset_q;

endmodule

// File: src/bar_config_regs.sv
`timescale 1ns/1ps

`include "vga_settings.svh"

module bar_config_regs (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    cfg_req,         // Four-phase request from host
    input  vga_pixel_pkg::cfg_cmd_t cfg_cmd,         // Stable while req is high
    output logic                    cfg_ack,
    output vga_pixel_pkg::bar_cfg_t cfg,             // Live configuration
    output logic                    divider_written  // Pulse on the divider write edge
);

    typedef enum logic {
        IDLE,   // Waiting for req
        ACKED   // Write done, waiting for req to drop
    } state_e;

    state_e                  state;
    logic                    wr_en;  // Accept the command on this edge
    vga_pixel_pkg::bar_cfg_t regs;

    // A new request is only taken while ack is low
    assign wr_en = (state == IDLE) && cfg_req;

    // Handshake FSM, ack is the state itself
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (cfg_req)  state <= ACKED;
                ACKED:   if (!cfg_req) state <= IDLE;  // Host released req
                default: state <= IDLE;
            endcase
        end
    end

    // Field write, narrow fields take the low bits
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            regs.width     <= vga_timing_pkg::h_pos_t'(`BAR_DEFAULT_WIDTH);
            regs.divider   <= vga_pixel_pkg::divider_t'(`BAR_DEFAULT_DIVIDER);
            regs.bar_color <= vga_pixel_pkg::rgb_t'(`BAR_DEFAULT_COLOR);
            regs.bg_color  <= vga_pixel_pkg::rgb_t'(`BG_DEFAULT_COLOR);
        end else if (wr_en) begin
            case (cfg_cmd.field)
                vga_pixel_pkg::CFG_BAR_WIDTH:
                    regs.width <= cfg_cmd.value[9:0];
                vga_pixel_pkg::CFG_DIVIDER:
                    regs.divider <= cfg_cmd.value[19:0];
                vga_pixel_pkg::CFG_BAR_COLOR:
                    regs.bar_color <= vga_pixel_pkg::rgb_t'(cfg_cmd.value);
                vga_pixel_pkg::CFG_BG_COLOR:
                    regs.bg_color <= vga_pixel_pkg::rgb_t'(cfg_cmd.value);
                default: ;
            endcase
        end
    end

    assign cfg_ack = (state == ACKED);
    assign cfg     = regs;

    // Scroller restarts its step timing on the same edge as the write
    assign divider_written = wr_en && (cfg_cmd.field == vga_pixel_pkg::CFG_DIVIDER);

endmodule

// File: src/vga_raster_timer.sv
`timescale 1ns/1ps

`include "vga_settings.svh"

module vga_raster_timer (
    input  logic                         clk,
    input  logic                         reset_n,
    output vga_timing_pkg::h_pos_t       h_pos,       // Current column
    output vga_timing_pkg::v_pos_t       v_pos,       // Current line
    output vga_timing_pkg::sync_bundle_t sync,        // Decoded from the counters
    output logic                         frame_start  // First pixel of the frame
);

    vga_timing_pkg::h_pos_t h_cnt;
    vga_timing_pkg::v_pos_t v_cnt;
    logic                   h_last;  // Last pixel of the line
    logic                   v_last;  // Last line of the frame

    assign h_last = (h_cnt == vga_timing_pkg::h_pos_t'(`VGA_H_TOTAL - 1));
    assign v_last = (v_cnt == vga_timing_pkg::v_pos_t'(`VGA_V_TOTAL - 1));

    // Free-running raster, v steps on every line wrap
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                if (v_last)
                    v_cnt <= '0;  // End of frame
                else
                    v_cnt <= v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // Sync pulses are low between the front and back porch
    always_comb begin
        sync.h_sync   = ~((h_cnt >= vga_timing_pkg::h_pos_t'(`VGA_H_SYNC_START)) &&
                          (h_cnt <  vga_timing_pkg::h_pos_t'(`VGA_H_SYNC_END)));
        sync.v_sync   = ~((v_cnt >= vga_timing_pkg::v_pos_t'(`VGA_V_SYNC_START)) &&
                          (v_cnt <  vga_timing_pkg::v_pos_t'(`VGA_V_SYNC_END)));
        sync.video_on = (h_cnt < vga_timing_pkg::h_pos_t'(`VGA_H_ACTIVE)) &&
                        (v_cnt < vga_timing_pkg::v_pos_t'(`VGA_V_ACTIVE));
    end

    assign frame_start = (h_cnt == '0) && (v_cnt == '0);  // One cycle per frame
    assign h_pos       = h_cnt;
    assign v_pos       = v_cnt;

endmodule

// File: src/vga_pixel_pkg.sv
package vga_pixel_pkg;

    // One color channel
    typedef logic [7:0] color_t;

    // Full pixel, red in the top byte
    typedef struct packed {
        color_t red;
        color_t green;
        color_t blue;
    } rgb_t;

    // Clocks per scroll step
    typedef logic [19:0] divider_t;

    // Raw value carried by a configuration write
    typedef logic [23:0] cfg_value_t;

    // Register selected by a configuration write
    typedef enum logic [1:0] {
        CFG_BAR_WIDTH,
        CFG_DIVIDER,
        CFG_BAR_COLOR,
        CFG_BG_COLOR
    } cfg_field_e;

    // Host write: narrow fields take the low bits of value
    typedef struct packed {
        cfg_field_e field;
        cfg_value_t value;
    } cfg_cmd_t;

    // Live bar configuration
    typedef struct packed {
        vga_timing_pkg::h_pos_t width;  // Bar width in pixels
        divider_t               divider;
        rgb_t                   bar_color;
        rgb_t                   bg_color;
    } bar_cfg_t;

endpackage

// File: src/vga_timing_pkg.sv
package vga_timing_pkg;

    // Pixel column within the full line, 0 to 799
    typedef logic [9:0] h_pos_t;

    // Line number within the full frame, 0 to 524
    typedef logic [9:0] v_pos_t;

    // Sync and blanking flags that travel with each pixel
    typedef struct packed {
        logic h_sync;    // Active low
        logic v_sync;    // Active low
        logic video_on;  // High inside the 640x480 window
    } sync_bundle_t;

endpackage

// File: src/vga_settings.svh
`ifndef VGA_SETTINGS_SVH
`define VGA_SETTINGS_SVH

// Horizontal raster for 640x480@60, in pixel clocks
`define VGA_H_ACTIVE 640   // Visible pixels
`define VGA_H_FRONT  16    // Blanking before sync
`define VGA_H_SYNC   96    // Sync pulse width
`define VGA_H_BACK   48    // Blanking after sync
`define VGA_H_TOTAL  800   // Full line

// Vertical raster, in lines
`define VGA_V_ACTIVE 480   // Visible lines
`define VGA_V_FRONT  10
`define VGA_V_SYNC   2
`define VGA_V_BACK   33
`define VGA_V_TOTAL  525   // Full frame

// Sync pulse edges derived from the porches
`define VGA_H_SYNC_START (`VGA_H_ACTIVE + `VGA_H_FRONT)
`define VGA_H_SYNC_END   (`VGA_H_ACTIVE + `VGA_H_FRONT + `VGA_H_SYNC)
`define VGA_V_SYNC_START (`VGA_V_ACTIVE + `VGA_V_FRONT)
`define VGA_V_SYNC_END   (`VGA_V_ACTIVE + `VGA_V_FRONT + `VGA_V_SYNC)

// Power-up bar configuration
`define BAR_DEFAULT_WIDTH   100       // Pixels
`define BAR_DEFAULT_DIVIDER 500000    // Clocks per scroll step
`define BAR_DEFAULT_COLOR   24'h964B00 // Brown
`define BG_DEFAULT_COLOR    24'h0000FF // Blue

`endif
